// ==== common/aes_pkg.sv ====
package aes_pkg;

	// Block geometry
	localparam int NB     = 4;
	localparam int WORD_S = 32;
	localparam int BLK_S  = NB * WORD_S;
	localparam int NB_W   = $clog2(NB);

	// FIFO payload, mixer input and mixer output
	typedef struct packed {
		logic             last;
		logic [BLK_S-1:0] data;
	} aes_block_t;

	// One bus stream word
	typedef struct packed {
		logic [WORD_S-1:0] data;
		logic              last;
	} bus_word_t;

	// Byte 0 of the stream goes to the top byte of the block
	function automatic logic [BLK_S-1:0] blk_rev8(input logic [BLK_S-1:0] blk);
		logic [BLK_S-1:0] rev;
		for (int i = 0; i < BLK_S / 8; i++) begin
			rev[BLK_S - 8 * (i + 1) +: 8] = blk[8 * i +: 8];
		end
		return rev;
	endfunction

endpackage

// ==== verilog/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo #(
	parameter int  ADDR_WIDTH = 4,
	parameter type payload_t  = logic [7:0]
) (
	input  logic     w_clk,
	input  logic     w_reset,
	input  logic     write_valid,
	output logic     write_ready,
	input  payload_t write_data,

	input  logic     r_clk,
	input  logic     r_reset,
	output logic     read_valid,
	input  logic     read_ready,
	output payload_t read_data
);

	localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

	function automatic logic [ADDR_WIDTH:0] bin2gray(input logic [ADDR_WIDTH:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] g);
		logic [ADDR_WIDTH:0] b;
		b[ADDR_WIDTH] = g[ADDR_WIDTH];
		for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
			b[i] = b[i + 1] ^ g[i];
		end
		return b;
	endfunction

	payload_t mem [DEPTH];

	// Write domain
	logic [ADDR_WIDTH:0] wbin, wbin_next, wgray, wgray_next;
	logic [ADDR_WIDTH:0] rq1_gray, rq2_gray, rq2_bin, w_fill;
	logic                w_ready_q;
	logic                w_push;

	// Read domain
	logic [ADDR_WIDTH:0] rbin, rbin_next, rgray, rgray_next;
	logic [ADDR_WIDTH:0] wq1_gray, wq2_gray, wq2_bin, r_fill;
	logic                r_valid_q;
	logic                r_pop;

	assign write_ready = w_ready_q;
	assign w_push      = write_valid && w_ready_q;
	assign wbin_next   = wbin + {{ADDR_WIDTH{1'b0}}, w_push};
	assign wgray_next  = bin2gray(wbin_next);

	always_ff @(posedge w_clk) begin
		if (w_push) begin
			mem[wbin[ADDR_WIDTH-1:0]] <= write_data;
		end
	end

	always_ff @(posedge w_clk) begin
		if (w_reset) begin
			wbin      <= '0;
			wgray     <= '0;
			rq1_gray  <= '0;
			rq2_gray  <= '0;
			w_ready_q <= 1'b0;
		end else begin
			wbin      <= wbin_next;
			wgray     <= wgray_next;
			rq1_gray  <= rgray;
			rq2_gray  <= rq1_gray;
			// Full when the top two bits differ and the rest match
			w_ready_q <= wgray_next != {~rq2_gray[ADDR_WIDTH:ADDR_WIDTH-1],
				rq2_gray[ADDR_WIDTH-2:0]};
		end
	end

	assign read_valid = r_valid_q;
	assign read_data  = mem[rbin[ADDR_WIDTH-1:0]];
	assign r_pop      = r_valid_q && read_ready;
	assign rbin_next  = rbin + {{ADDR_WIDTH{1'b0}}, r_pop};
	assign rgray_next = bin2gray(rbin_next);

	always_ff @(posedge r_clk) begin
		if (r_reset) begin
			rbin      <= '0;
			rgray     <= '0;
			wq1_gray  <= '0;
			wq2_gray  <= '0;
			r_valid_q <= 1'b0;
		end else begin
			rbin      <= rbin_next;
			rgray     <= rgray_next;
			wq1_gray  <= wgray;
			wq2_gray  <= wq1_gray;
			r_valid_q <= rgray_next != wq2_gray;
		end
	end

	// Occupancy as each side sees it through its synchronizer
	assign rq2_bin = gray2bin(rq2_gray);
	assign w_fill  = wbin - rq2_bin;
	assign wq2_bin = gray2bin(wq2_gray);
	assign r_fill  = wq2_bin - rbin;

	a_no_write_when_full: assert property (@(posedge w_clk) disable iff (w_reset)
		w_push |-> w_fill < DEPTH);

	a_no_read_when_empty: assert property (@(posedge r_clk) disable iff (r_reset)
		r_pop |-> r_fill != '0);

endmodule

// ==== aes_controller/aes_controller_input.sv ====
`timescale 1ns/1ps

module aes_controller_input
	import aes_pkg::*;
#(
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic       bus_clk,
	input  logic       bus_reset,
	input  logic       aes_clk,
	input  logic       aes_reset,

	input  logic       in_valid,
	output logic       in_ready,
	input  bus_word_t  in_word,

	output logic       blk_valid,
	input  logic       blk_ready,
	output aes_block_t blk
);

	logic [NB_W-1:0]            word_cnt;
	logic [WORD_S*(NB-1)-1:0]   asm_q;
	aes_block_t                 blk_q;
	logic                       blk_pend;
	logic                       fifo_ready;
	logic                       in_accept;
	logic                       last_word;

	// Words flow only while the FIFO has room
	assign in_ready  = fifo_ready;
	assign in_accept = in_valid && in_ready;
	assign last_word = word_cnt == NB_W'(NB - 1);

	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			word_cnt <= '0;
		end else if (in_accept) begin
			if (last_word) begin
				word_cnt <= '0;
			end else begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// Words 0..2 wait here, word 3 completes the block
	always_ff @(posedge bus_clk) begin
		if (in_accept && !last_word) begin
			asm_q[word_cnt * WORD_S +: WORD_S] <= in_word.data;
		end
		if (in_accept && last_word) begin
			blk_q.data <= blk_rev8({in_word.data, asm_q});
			blk_q.last <= in_word.last;
		end
	end

	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			blk_pend <= 1'b0;
		end else if (in_accept && last_word) begin
			blk_pend <= 1'b1;
		end else if (fifo_ready) begin
			blk_pend <= 1'b0;
		end
	end

	async_fifo #(
		.ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.payload_t (aes_block_t)
	) in_fifo (
		.w_clk      (bus_clk),
		.w_reset    (bus_reset),
		.write_valid(blk_pend),
		.write_ready(fifo_ready),
		.write_data (blk_q),

		.r_clk      (aes_clk),
		.r_reset    (aes_reset),
		.read_valid (blk_valid),
		.read_ready (blk_ready),
		.read_data  (blk)
	);

	a_last_on_word3: assert property (@(posedge bus_clk) disable iff (bus_reset)
		(in_accept && !last_word) |-> !in_word.last);

endmodule

// ==== aes_controller/aes_controller_output.sv ====
`timescale 1ns/1ps

module aes_controller_output
	import aes_pkg::*;
#(
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic              bus_clk,
	input  logic              bus_reset,
	input  logic              aes_clk,
	input  logic              aes_reset,

	input  logic              res_valid,
	output logic              res_ready,
	input  aes_block_t        res_blk,

	output logic              bus_tvalid,
	input  logic              bus_tready,
	output logic [WORD_S-1:0] bus_tdata,
	output logic              bus_tlast
);

	aes_block_t       fifo_rdata;
	logic             fifo_rvalid;
	logic             fifo_rready;
	logic             fifo_pop;

	logic [BLK_S-1:0] data_q;
	logic             last_q;
	logic             loaded;
	logic [NB_W-1:0]  word_cnt;
	logic             bus_xfer;
	logic             last_word;

	async_fifo #(
		.ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.payload_t (aes_block_t)
	) out_fifo (
		// Write side in the aes domain
		.w_clk      (aes_clk),
		.w_reset    (aes_reset),
		.write_valid(res_valid),
		.write_ready(res_ready),
		.write_data (res_blk),

		// Read side in the bus domain
		.r_clk      (bus_clk),
		.r_reset    (bus_reset),
		.read_valid (fifo_rvalid),
		.read_ready (fifo_rready),
		.read_data  (fifo_rdata)
	);

	assign fifo_rready = !loaded;
	assign fifo_pop    = fifo_rvalid && fifo_rready;

	assign last_word  = word_cnt == NB_W'(NB - 1);
	assign bus_tvalid = loaded;
	assign bus_tdata  = data_q[word_cnt * WORD_S +: WORD_S];
	assign bus_tlast  = last_q && last_word;
	assign bus_xfer   = bus_tvalid && bus_tready;

	// Stored in stream byte order, word k at bits 32k+31:32k
	always_ff @(posedge bus_clk) begin
		if (fifo_pop) begin
			data_q <= blk_rev8(fifo_rdata.data);
		end
	end

	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			loaded <= 1'b0;
			last_q <= 1'b0;
		end else if (fifo_pop) begin
			loaded <= 1'b1;
			last_q <= fifo_rdata.last;
		end else if (bus_xfer && last_word) begin
			loaded <= 1'b0;
			last_q <= 1'b0;
		end
	end

	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			word_cnt <= '0;
		end else if (bus_xfer) begin
			if (last_word) begin
				word_cnt <= '0;
			end else begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/aes_ctr_mixer.sv ====
`timescale 1ns/1ps

module aes_ctr_mixer
	import aes_pkg::*;
(
	input  logic             aes_clk,
	input  logic             aes_reset,

	input  logic             data_valid,
	output logic             data_ready,
	input  aes_block_t       data_blk,

	input  logic             ks_valid,
	output logic             ks_ready,
	input  logic [BLK_S-1:0] ks_block,

	output logic             res_valid,
	input  logic             res_ready,
	output aes_block_t       res_blk
);

	logic       res_valid_q;
	aes_block_t res_blk_q;
	logic       take;

	// Join: both sides move together, only when the output slot frees up
	assign take       = data_valid && ks_valid && (!res_valid_q || res_ready);
	assign data_ready = take;
	assign ks_ready   = take;

	assign res_valid = res_valid_q;
	assign res_blk   = res_blk_q;

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			res_valid_q <= 1'b0;
		end else if (take) begin
			res_valid_q <= 1'b1;
		end else if (res_ready) begin
			res_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge aes_clk) begin
		if (take) begin
			res_blk_q.data <= data_blk.data ^ ks_block;
			res_blk_q.last <= data_blk.last;
		end
	end

	a_res_holds: assert property (@(posedge aes_clk) disable iff (aes_reset)
		(res_valid && !res_ready) |=> res_valid && $stable(res_blk));

endmodule

// ==== verilog/aes_ctr_datapath.sv ====
`timescale 1ns/1ps

module aes_ctr_datapath
	import aes_pkg::*;
#(
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input  logic              bus_clk,
	input  logic              bus_reset,
	input  logic              aes_clk,
	input  logic              aes_reset,

	input  logic              in_valid,
	output logic              in_ready,
	input  bus_word_t         in_word,

	input  logic              ks_valid,
	output logic              ks_ready,
	input  logic [BLK_S-1:0]  ks_block,

	output logic              bus_tvalid,
	input  logic              bus_tready,
	output logic [WORD_S-1:0] bus_tdata,
	output logic              bus_tlast
);

	// Input FIFO to mixer
	logic       blk_valid;
	logic       blk_ready;
	aes_block_t blk;

	// Mixer to output FIFO
	logic       res_valid;
	logic       res_ready;
	aes_block_t res_blk;

	aes_controller_input #(
		.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
	) u_input (
		.bus_clk  (bus_clk),
		.bus_reset(bus_reset),
		.aes_clk  (aes_clk),
		.aes_reset(aes_reset),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_word  (in_word),
		.blk_valid(blk_valid),
		.blk_ready(blk_ready),
		.blk      (blk)
	);

	aes_ctr_mixer u_mixer (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.data_valid(blk_valid),
		.data_ready(blk_ready),
		.data_blk  (blk),
		.ks_valid  (ks_valid),
		.ks_ready  (ks_ready),
		.ks_block  (ks_block),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_blk   (res_blk)
	);

	aes_controller_output #(
		.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
	) u_output (
		.bus_clk   (bus_clk),
		.bus_reset (bus_reset),
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_blk   (res_blk),
		.bus_tvalid(bus_tvalid),
		.bus_tready(bus_tready),
		.bus_tdata (bus_tdata),
		.bus_tlast (bus_tlast)
	);

endmodule

// ==== testbench/tb_aes_ctr_datapath.sv ====
`timescale 1ns/1ps

module tb_aes_ctr_datapath
	import aes_pkg::*;
;

	localparam int          FIFO_AW      = 2;
	localparam int          N_VEC        = 32;
	localparam int          LIMIT        = N_VEC * 40 + 200;
	localparam int          STALL_AT     = 6;
	localparam int          STALL_CYCLES = 200;
	localparam int          LONG_GAP     = 40;
	localparam logic [31:0] SEED         = 32'haf10_c727;

	typedef struct packed {
		logic [NB-1:0][WORD_S-1:0] words;
		logic [BLK_S-1:0]          ks;
		logic                      last;
		logic [NB-1:0][WORD_S-1:0] exp;
	} vec_t;

	logic              bus_clk, aes_clk, bus_reset, aes_reset;
	logic              in_valid, in_ready, ks_valid, ks_ready;
	bus_word_t         in_word;
	logic [BLK_S-1:0]  ks_block;
	logic              bus_tvalid, bus_tready, bus_tlast;
	logic [WORD_S-1:0] bus_tdata;

	vec_t        vectors [N_VEC];
	bus_word_t   exp_q [$];
	bus_word_t   mon_word, exp_word, held_word, drv_word;
	logic        held_valid;
	logic        stall_out;
	logic [31:0] tbl_lcg, in_lcg, ks_lcg, out_lcg;
	int          data_errs, last_errs, flag_errs, other_errs;
	int          out_count, blocks_sent, cycles;

	aes_ctr_datapath #(
		.FIFO_ADDR_WIDTH(FIFO_AW)
	) dut (
		.bus_clk   (bus_clk),
		.bus_reset (bus_reset),
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_word   (in_word),
		.ks_valid  (ks_valid),
		.ks_ready  (ks_ready),
		.ks_block  (ks_block),
		.bus_tvalid(bus_tvalid),
		.bus_tready(bus_tready),
		.bus_tdata (bus_tdata),
		.bus_tlast (bus_tlast)
	);

	initial begin
		bus_clk = 1'b0;
		forever #4 bus_clk = ~bus_clk;
	end

	initial begin
		aes_clk = 1'b0;
		forever #5 aes_clk = ~aes_clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Stream byte i is bits 8(i%4) of word i/4, keystream byte i is bits 127-8i
	function automatic logic [NB-1:0][WORD_S-1:0] ctr_model(
		input logic [NB-1:0][WORD_S-1:0] words, input logic [BLK_S-1:0] ks);
		logic [NB-1:0][WORD_S-1:0] res;
		for (int i = 0; i < NB * 4; i++) begin
			res[i / 4][8 * (i % 4) +: 8] = words[i / 4][8 * (i % 4) +: 8]
				^ ks[BLK_S - 8 * (i + 1) +: 8];
		end
		return res;
	endfunction

	task automatic check_word(input bus_word_t exp, input bus_word_t got, input string name);
		if (got.data !== exp.data) begin
			data_errs++;
			$display("error at %t: %s expected %h got %h", $time, name, exp.data, got.data);
		end
	endtask

	task automatic check_last(input logic exp, input logic got, input string name);
		if (got !== exp) begin
			last_errs++;
			$display("error at %t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_flag(input logic exp, input logic got, input string name);
		if (got !== exp) begin
			flag_errs++;
			$display("error at %t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_word(input bus_word_t w);
		in_lcg = lcg_step(in_lcg);
		while (in_lcg[31:29] == 3'd0) begin
			in_valid = 1'b0;
			@(negedge bus_clk);
			in_lcg = lcg_step(in_lcg);
		end
		in_valid = 1'b1;
		in_word  = w;
		#1;
		while (!in_ready) begin
			@(negedge bus_clk);
			#1;
		end
		@(negedge bus_clk);
	endtask

	task automatic send_ks(input logic [BLK_S-1:0] ks);
		ks_lcg = lcg_step(ks_lcg);
		while (ks_lcg[31:30] == 2'd0) begin
			ks_valid = 1'b0;
			@(negedge aes_clk);
			ks_lcg = lcg_step(ks_lcg);
		end
		ks_valid = 1'b1;
		ks_block = ks;
		#1;
		while (!ks_ready) begin
			@(negedge aes_clk);
			#1;
		end
		@(negedge aes_clk);
	endtask

	// Output side: random back-pressure, hold check and in-order compare
	initial begin
		held_valid = 1'b0;
		forever begin
			@(negedge bus_clk);
			out_lcg    = lcg_step(out_lcg);
			bus_tready = !stall_out && (out_lcg[31:30] != 2'b00);
			#1;
			mon_word.data = bus_tdata;
			mon_word.last = bus_tlast;
			if (held_valid) begin
				check_flag(1'b1, bus_tvalid, "bus_tvalid (held)");
				check_word(held_word, mon_word, "bus_tdata (held)");
				check_last(held_word.last, bus_tlast, "bus_tlast (held)");
			end
			if (bus_tvalid && bus_tready) begin
				if (exp_q.size() == 0) begin
					other_errs++;
					$display("error at %t: output word %h came out with nothing left to expect",
						$time, bus_tdata);
				end else begin
					exp_word = exp_q.pop_front();
					check_word(exp_word, mon_word, "bus_tdata");
					check_last(exp_word.last, bus_tlast, "bus_tlast");
				end
				out_count++;
			end
			held_valid = bus_tvalid && !bus_tready;
			held_word  = mon_word;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge bus_clk);
			cycles++;
		end
		$display("timeout after %0d bus_clk cycles, %0d of %0d words received",
			cycles, out_count, N_VEC * NB);
		$display("Regression failed");
		$finish;
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		bus_reset   = 1'b1;
		aes_reset   = 1'b1;
		in_valid    = 1'b0;
		in_word     = '0;
		ks_valid    = 1'b0;
		ks_block    = '0;
		bus_tready  = 1'b0;
		stall_out   = 1'b0;
		data_errs   = 0;
		last_errs   = 0;
		flag_errs   = 0;
		other_errs  = 0;
		out_count   = 0;
		blocks_sent = 0;
		tbl_lcg     = SEED;
		in_lcg      = lcg_step(SEED ^ 32'h0000_00ff);
		ks_lcg      = lcg_step(SEED ^ 32'h0000_ff00);
		out_lcg     = lcg_step(SEED ^ 32'h00ff_0000);

		// Entry 0 passes through unchanged, the rest are random
		for (int i = 0; i < N_VEC; i++) begin
			for (int k = 0; k < NB; k++) begin
				tbl_lcg = lcg_step(tbl_lcg);
				vectors[i].words[k] = tbl_lcg;
				tbl_lcg = lcg_step(tbl_lcg);
				vectors[i].ks[WORD_S * k +: WORD_S] = tbl_lcg;
			end
			tbl_lcg = lcg_step(tbl_lcg);
			vectors[i].last = tbl_lcg[31] || (i == N_VEC - 1);
			if (i == 0) begin
				vectors[i].words = {32'h0f0e0d0c, 32'h0b0a0908, 32'h07060504, 32'h03020100};
				vectors[i].ks    = '0;
				vectors[i].last  = 1'b1;
			end
			vectors[i].exp = ctr_model(vectors[i].words, vectors[i].ks);
			for (int k = 0; k < NB; k++) begin
				exp_word.data = vectors[i].exp[k];
				exp_word.last = vectors[i].last && (k == NB - 1);
				exp_q.push_back(exp_word);
			end
		end

		// Keystream offered with no data block behind it
		ks_valid = 1'b1;
		ks_block = vectors[0].ks;

		repeat (10) begin
			@(negedge bus_clk);
			check_flag(1'b0, in_ready, "in_ready");
			check_flag(1'b0, ks_ready, "ks_ready");
			check_flag(1'b0, bus_tvalid, "bus_tvalid");
		end
		bus_reset = 1'b0;
		aes_reset = 1'b0;

		// Idle: nothing may come out before input arrives
		repeat (20) begin
			@(negedge bus_clk);
			check_flag(1'b0, bus_tvalid, "bus_tvalid");
			check_flag(1'b0, ks_ready, "ks_ready");
		end
		check_flag(1'b1, in_ready, "in_ready");

		fork
			begin
				for (int i = 0; i < N_VEC; i++) begin
					for (int k = 0; k < NB; k++) begin
						drv_word.data = vectors[i].words[k];
						drv_word.last = vectors[i].last && (k == NB - 1);
						send_word(drv_word);
					end
					blocks_sent++;
				end
				in_valid = 1'b0;
			end
			begin
				@(negedge aes_clk);
				for (int i = 0; i < N_VEC; i++) begin
					if (i % 8 == 4) begin
						ks_valid = 1'b0;
						repeat (LONG_GAP) @(negedge aes_clk);
					end
					send_ks(vectors[i].ks);
				end
				ks_valid = 1'b0;
			end
			begin
				wait (blocks_sent >= STALL_AT);
				@(negedge bus_clk);
				stall_out = 1'b1;
				repeat (STALL_CYCLES) @(negedge bus_clk);
				stall_out = 1'b0;
			end
		join

		while (out_count < N_VEC * NB) begin
			@(negedge bus_clk);
		end
		repeat (50) @(negedge bus_clk);
		if (exp_q.size() != 0) begin
			other_errs++;
			$display("%0d expected words never came out", exp_q.size());
		end

		$display("errors: data %0d, last %0d, control %0d, other %0d",
			data_errs, last_errs, flag_errs, other_errs);
		if (data_errs + last_errs + flag_errs + other_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== aes_ctr_datapath.f ====
common/aes_pkg.sv
verilog/async_fifo.sv
aes_controller/aes_controller_input.sv
aes_controller/aes_controller_output.sv
verilog/aes_ctr_mixer.sv
verilog/aes_ctr_datapath.sv
testbench/tb_aes_ctr_datapath.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_aes_ctr_datapath -f aes_ctr_datapath.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
